// File: rename_cfg_pkg.sv
`default_nettype none

package rename_cfg_pkg;

    // architectural side
    localparam int num_arch_regs = 32;
    localparam int arch_idx_w    = 5;   // log2 of num_arch_regs

    // physical side
    localparam int num_phys_regs = 128;
    localparam int phys_tag_w    = 7;   // log2 of num_phys_regs

    // free list pointer carries one extra wrap bit so full and empty differ
    localparam int fl_ptr_w = phys_tag_w + 1;

    // branch checkpoints
    localparam int num_ckpt   = 8;
    localparam int ckpt_idx_w = 3;

    // tags not claimed by the identity map after reset (32 .. 127)
    localparam int init_free_count = num_phys_regs - num_arch_regs;

endpackage

`default_nettype wire

// File: rename_if_pkg.sv
`default_nettype none

package rename_if_pkg;

    typedef logic [rename_cfg_pkg::phys_tag_w-1:0] phys_tag_t;
    typedef logic [rename_cfg_pkg::arch_idx_w-1:0] arch_idx_t;
    typedef logic [rename_cfg_pkg::fl_ptr_w-1:0]   fl_ptr_t;

    // full architectural-to-physical map, entry i belongs to arch reg i
    typedef phys_tag_t [rename_cfg_pkg::num_arch_regs-1:0] map_image_t;

    typedef struct packed {
        logic      valid;
        logic      has_dest;
        arch_idx_t dest;
        arch_idx_t src1;
        arch_idx_t src2;
    } rename_req_t;

    typedef struct packed {
        logic      valid;
        phys_tag_t src1_tag;
        phys_tag_t src2_tag;
        phys_tag_t dest_tag;    // zero when no destination
        phys_tag_t old_tag;     // previous mapping of dest, freed at commit
    } rename_rsp_t;

    typedef struct packed {
        logic      valid;
        phys_tag_t tag;
    } release_t;

    typedef struct packed {
        logic                                save;
        logic [rename_cfg_pkg::ckpt_idx_w-1:0] save_slot;
        logic                                restore;
        logic [rename_cfg_pkg::ckpt_idx_w-1:0] restore_slot;
    } ckpt_cmd_t;

    // arch reg i maps to phys tag i out of reset
    function automatic map_image_t identity_image();
        map_image_t img;
        for (int i = 0; i < rename_cfg_pkg::num_arch_regs; i++) begin
            img[i] = phys_tag_t'(i);
        end
        return img;
    endfunction

endpackage

`default_nettype wire

// File: free_list.sv
`timescale 1ns/1ps
`default_nettype none

module free_list (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   alloc,
    input  wire rename_if_pkg::release_t rel,
    input  wire logic                   restore,
    input  wire rename_if_pkg::fl_ptr_t  restore_head,
    output rename_if_pkg::phys_tag_t    head_tag,
    output rename_if_pkg::fl_ptr_t      head_next,
    output logic                        nonempty
);

    // circular store of free tags
    rename_if_pkg::phys_tag_t fl_mem [rename_cfg_pkg::num_phys_regs];

    rename_if_pkg::fl_ptr_t head_q;
    rename_if_pkg::fl_ptr_t tail_q;
    rename_if_pkg::fl_ptr_t tail_next;
    rename_if_pkg::fl_ptr_t free_count;

    // low bits address the store, top bit is the wrap flag
    logic [rename_cfg_pkg::fl_ptr_w-2:0] head_idx;
    logic [rename_cfg_pkg::fl_ptr_w-2:0] tail_idx;

    assign head_idx = head_q[rename_cfg_pkg::fl_ptr_w-2:0];
    assign tail_idx = tail_q[rename_cfg_pkg::fl_ptr_w-2:0];

    assign free_count = tail_q - head_q;    // wraps cleanly in fl_ptr_w bits
    assign nonempty   = (free_count != '0);
    assign head_tag   = fl_mem[head_idx];

    // head after this edge, also what a save captures
    always_comb begin
        head_next = head_q;
        if (restore) begin
            head_next = restore_head;   // roll back, tail keeps later releases
        end else if (alloc) begin
            head_next = head_q + 1'b1;
        end
    end

    always_comb begin
        tail_next = tail_q;
        if (rel.valid) begin
            tail_next = tail_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            head_q <= '0;
            tail_q <= rename_if_pkg::fl_ptr_t'(rename_cfg_pkg::init_free_count);
        end else begin
            head_q <= head_next;
            tail_q <= tail_next;
        end
    end

    // tag storage, preloaded with 32 .. 127 in order
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < rename_cfg_pkg::init_free_count; i++) begin
                fl_mem[i] <= rename_if_pkg::phys_tag_t'(rename_cfg_pkg::num_arch_regs + i);
            end
        end else if (rel.valid) begin
            fl_mem[tail_idx] <= rel.tag;    // released tag joins the back
        end
    end

endmodule

`default_nettype wire

// File: map_table.sv
`timescale 1ns/1ps
`default_nettype none

module map_table (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire rename_if_pkg::arch_idx_t  src1,
    input  wire rename_if_pkg::arch_idx_t  src2,
    input  wire rename_if_pkg::arch_idx_t  dest,
    input  wire logic                      update,
    input  wire rename_if_pkg::phys_tag_t  new_tag,
    input  wire logic                      restore,
    input  wire rename_if_pkg::map_image_t restore_image,
    output rename_if_pkg::phys_tag_t       src1_tag,
    output rename_if_pkg::phys_tag_t       src2_tag,
    output rename_if_pkg::phys_tag_t       old_tag,
    output rename_if_pkg::map_image_t      image_next
);

    rename_if_pkg::map_image_t map_q;   // current mapping

    // lookups see the table before this cycle's write
    assign src1_tag = map_q[src1];
    assign src2_tag = map_q[src2];
    assign old_tag  = map_q[dest];

    // table contents after this edge
    always_comb begin
        image_next = map_q;
        if (restore) begin
            image_next = restore_image;     // whole table back from snapshot
        end else if (update) begin
            image_next[dest] = new_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            map_q <= rename_if_pkg::identity_image();
        end else begin
            map_q <= image_next;
        end
    end

endmodule

`default_nettype wire

// File: checkpoint_store.sv
`timescale 1ns/1ps
`default_nettype none

module checkpoint_store #(
    parameter type payload_t = logic
) (
    input  wire logic                                  clk,
    input  wire logic                                  reset,
    input  wire logic                                  save,
    input  wire logic [rename_cfg_pkg::ckpt_idx_w-1:0] save_slot,
    input  wire logic [rename_cfg_pkg::ckpt_idx_w-1:0] restore_slot,
    input  wire payload_t                              wr_data,
    input  wire payload_t                              reset_value,
    output payload_t                                   rd_data
);

    payload_t slot_mem [rename_cfg_pkg::num_ckpt];

    // every slot starts as the reset image so a stray restore is harmless
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < rename_cfg_pkg::num_ckpt; i++) begin
                slot_mem[i] <= reset_value;
            end
        end else if (save) begin
            slot_mem[save_slot] <= wr_data;
        end
    end

    assign rd_data = slot_mem[restore_slot];   // unregistered read

endmodule

`default_nettype wire

// File: rename_unit.sv
`timescale 1ns/1ps
`default_nettype none

module rename_unit (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire rename_if_pkg::rename_req_t req,
    input  wire rename_if_pkg::release_t   rel,
    input  wire rename_if_pkg::ckpt_cmd_t  ckpt,
    output rename_if_pkg::rename_rsp_t     rsp,
    output logic                           ready
);

    logic accept;
    logic alloc;
    logic nonempty;

    rename_if_pkg::phys_tag_t  head_tag;
    rename_if_pkg::fl_ptr_t    head_next;
    rename_if_pkg::fl_ptr_t    saved_head;
    rename_if_pkg::phys_tag_t  src1_tag;
    rename_if_pkg::phys_tag_t  src2_tag;
    rename_if_pkg::phys_tag_t  old_tag;
    rename_if_pkg::map_image_t image_next;
    rename_if_pkg::map_image_t saved_image;
    rename_if_pkg::rename_rsp_t rsp_q;

    assign ready = nonempty;

    // no dest needs no free tag, restore owns the cycle
    assign accept = req.valid && (!req.has_dest || ready) && !ckpt.restore;
    assign alloc  = accept && req.has_dest;

    free_list i_free_list (
        .clk          (clk),
        .reset        (reset),
        .alloc        (alloc),
        .rel          (rel),
        .restore      (ckpt.restore),
        .restore_head (saved_head),
        .head_tag     (head_tag),
        .head_next    (head_next),
        .nonempty     (nonempty)
    );

    map_table i_map_table (
        .clk           (clk),
        .reset         (reset),
        .src1          (req.src1),
        .src2          (req.src2),
        .dest          (req.dest),
        .update        (alloc),
        .new_tag       (head_tag),
        .restore       (ckpt.restore),
        .restore_image (saved_image),
        .src1_tag      (src1_tag),
        .src2_tag      (src2_tag),
        .old_tag       (old_tag),
        .image_next    (image_next)
    );

    // snapshots take post-edge state, so the branch's own rename is inside
    checkpoint_store #(.payload_t(rename_if_pkg::fl_ptr_t)) i_ckpt_head (
        .clk          (clk),
        .reset        (reset),
        .save         (ckpt.save),
        .save_slot    (ckpt.save_slot),
        .restore_slot (ckpt.restore_slot),
        .wr_data      (head_next),
        .reset_value  (rename_if_pkg::fl_ptr_t'(0)),
        .rd_data      (saved_head)
    );

    checkpoint_store #(.payload_t(rename_if_pkg::map_image_t)) i_ckpt_map (
        .clk          (clk),
        .reset        (reset),
        .save         (ckpt.save),
        .save_slot    (ckpt.save_slot),
        .restore_slot (ckpt.restore_slot),
        .wr_data      (image_next),
        .reset_value  (rename_if_pkg::identity_image()),
        .rd_data      (saved_image)
    );

    // response one cycle after acceptance
    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_q.valid <= 1'b0;
        end else begin
            rsp_q.valid <= accept;
            if (accept) begin
                rsp_q.src1_tag <= src1_tag;
                rsp_q.src2_tag <= src2_tag;
                rsp_q.dest_tag <= alloc ? head_tag : '0;
                rsp_q.old_tag  <= alloc ? old_tag : '0;
            end
        end
    end

    assign rsp = rsp_q;

endmodule

`default_nettype wire

// File: rename_unit_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module rename_unit_assertions (
    input wire logic                   clk,
    input wire logic                   reset,
    input wire logic                   accept,
    input wire logic                   rsp_valid,
    input wire logic                   save,
    input wire logic                   restore,
    input wire logic                   ready,
    input wire rename_if_pkg::fl_ptr_t free_count
);

    int fail_count = 0;     // watched by the testbench

    rsp_after_accept: assert property (@(posedge clk) disable iff (reset)
        accept |=> rsp_valid)
    else begin
        fail_count++;
        $error("rsp.valid missing one cycle after an accepted request");
    end

    no_rsp_without_accept: assert property (@(posedge clk) disable iff (reset)
        !accept |=> !rsp_valid)
    else begin
        fail_count++;
        $error("rsp.valid high without an accepted request");
    end

    no_save_with_restore: assert property (@(posedge clk) disable iff (reset)
        !(save && restore))
    else begin
        fail_count++;
        $error("checkpoint save and restore in the same cycle");
    end

    ready_when_full: assert property (@(posedge clk) disable iff (reset)
        (free_count == rename_cfg_pkg::init_free_count) |-> ready)
    else begin
        fail_count++;
        $error("ready low although the free list holds its reset count");
    end

endmodule

bind rename_unit rename_unit_assertions i_rename_asrt (
    .clk        (clk),
    .reset      (reset),
    .accept     (accept),
    .rsp_valid  (rsp.valid),
    .save       (ckpt.save),
    .restore    (ckpt.restore),
    .ready      (ready),
    .free_count (i_free_list.free_count)
);

`default_nettype wire

// File: tb_rename_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rename_unit;

    localparam int clk_period_ns = 4;
    localparam int cycle_budget  = 2000;   // tests use a few hundred cycles
    localparam int watchdog_ns   = cycle_budget * clk_period_ns * 5 / 2;

    logic clk;
    logic reset;
    rename_if_pkg::rename_req_t req;
    rename_if_pkg::release_t    rel;
    rename_if_pkg::ckpt_cmd_t   ckpt;
    rename_if_pkg::rename_rsp_t rsp;
    logic ready;

    rename_if_pkg::rename_req_t idle_req  = '0;
    rename_if_pkg::release_t    idle_rel  = '0;
    rename_if_pkg::ckpt_cmd_t   idle_ckpt = '0;
    rename_if_pkg::rename_rsp_t last_rsp;

    // reference model state
    rename_if_pkg::phys_tag_t  m_fl [rename_cfg_pkg::num_phys_regs];
    rename_if_pkg::fl_ptr_t    m_head;
    rename_if_pkg::fl_ptr_t    m_tail;
    rename_if_pkg::map_image_t m_map;
    rename_if_pkg::fl_ptr_t    snap_head [rename_cfg_pkg::num_ckpt];
    rename_if_pkg::map_image_t snap_map [rename_cfg_pkg::num_ckpt];
    rename_if_pkg::phys_tag_t  rel_q [$];   // tags released, in order

    logic [15:0] lfsr_q = 16'd75;

    rename_unit i_dut (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .rel   (rel),
        .ckpt  (ckpt),
        .rsp   (rsp),
        .ready (ready)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period_ns / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: the rename tests did not finish within %0d ns", watchdog_ns);
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        wait (i_dut.i_rename_asrt.fail_count != 0);
        $display("a concurrent assertion in the bound checker failed at %0d ns", $time);
        $display("tests failed");
        $fatal(1, "stopped at the first error");
    end

    // x^16 + x^14 + x^13 + x^11, one step per bit
    function automatic rename_if_pkg::arch_idx_t random_arch_idx();
        rename_if_pkg::arch_idx_t v;
        logic fb;
        v = '0;
        for (int i = 0; i < rename_cfg_pkg::arch_idx_w; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            v      = {v[rename_cfg_pkg::arch_idx_w-2:0], fb};
        end
        return v;
    endfunction

    function automatic rename_if_pkg::rename_req_t make_req(input logic has_dest,
                                                            input rename_if_pkg::arch_idx_t dest,
                                                            input rename_if_pkg::arch_idx_t src1,
                                                            input rename_if_pkg::arch_idx_t src2);
        rename_if_pkg::rename_req_t r;
        r.valid    = 1'b1;
        r.has_dest = has_dest;
        r.dest     = dest;
        r.src1     = src1;
        r.src2     = src2;
        return r;
    endfunction

    function automatic rename_if_pkg::ckpt_cmd_t make_ckpt(input logic save, input int sslot,
                                                           input logic restore, input int rslot);
        rename_if_pkg::ckpt_cmd_t c;
        c.save         = save;
        c.save_slot    = sslot[rename_cfg_pkg::ckpt_idx_w-1:0];
        c.restore      = restore;
        c.restore_slot = rslot[rename_cfg_pkg::ckpt_idx_w-1:0];
        return c;
    endfunction

    function automatic int model_free_count();
        rename_if_pkg::fl_ptr_t n;
        n = m_tail - m_head;
        return int'(n);
    endfunction

    task automatic check_value(input int got, input int exp, input string what);
        assert (got == exp) else begin
            $display("Mismatch at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
            $display("tests failed");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic model_reset();
        for (int i = 0; i < rename_cfg_pkg::num_arch_regs; i++) begin
            m_map[i] = rename_if_pkg::phys_tag_t'(i);
        end
        for (int i = 0; i < rename_cfg_pkg::num_phys_regs; i++) begin
            m_fl[i] = rename_if_pkg::phys_tag_t'(rename_cfg_pkg::num_arch_regs + i);
        end
        m_head = '0;
        m_tail = rename_if_pkg::fl_ptr_t'(rename_cfg_pkg::init_free_count);
        for (int s = 0; s < rename_cfg_pkg::num_ckpt; s++) begin
            snap_head[s] = '0;
            snap_map[s]  = m_map;
        end
    endtask

    // one clock of stimulus, response checked at the next falling edge
    task automatic drive_cycle(input rename_if_pkg::rename_req_t r,
                               input rename_if_pkg::release_t rl,
                               input rename_if_pkg::ckpt_cmd_t c);
        rename_if_pkg::rename_rsp_t exp;
        logic accepted;
        logic popped;
        check_value(ready, model_free_count() != 0, "ready");
        accepted = r.valid && (!r.has_dest || model_free_count() != 0) && !c.restore;
        popped   = accepted && r.has_dest;
        exp       = '0;
        exp.valid = accepted;
        if (accepted) begin
            exp.src1_tag = m_map[r.src1];
            exp.src2_tag = m_map[r.src2];
        end
        if (popped) begin
            exp.dest_tag = m_fl[m_head[rename_cfg_pkg::phys_tag_w-1:0]];
            exp.old_tag  = m_map[r.dest];
        end
        req  = r;
        rel  = rl;
        ckpt = c;
        @(negedge clk);
        last_rsp = rsp;
        check_value(rsp.valid, exp.valid, "rsp.valid");
        if (exp.valid) begin
            check_value(rsp.src1_tag, exp.src1_tag, "rsp.src1_tag");
            check_value(rsp.src2_tag, exp.src2_tag, "rsp.src2_tag");
            check_value(rsp.dest_tag, exp.dest_tag, "rsp.dest_tag");
            check_value(rsp.old_tag, exp.old_tag, "rsp.old_tag");
        end
        if (c.restore) begin
            m_head = snap_head[c.restore_slot];
            m_map  = snap_map[c.restore_slot];
        end else if (popped) begin
            m_map[r.dest] = exp.dest_tag;
            m_head        = m_head + 1'b1;
        end
        if (rl.valid) begin
            m_fl[m_tail[rename_cfg_pkg::phys_tag_w-1:0]] = rl.tag;
            m_tail = m_tail + 1'b1;
        end
        if (c.save) begin
            snap_head[c.save_slot] = m_head;    // post-edge state
            snap_map[c.save_slot]  = m_map;
        end
        req  = '0;
        rel  = '0;
        ckpt = '0;
    endtask

    task automatic rename_op(input logic has_dest, input rename_if_pkg::arch_idx_t dest,
                             input rename_if_pkg::arch_idx_t src1,
                             input rename_if_pkg::arch_idx_t src2);
        drive_cycle(make_req(has_dest, dest, src1, src2), idle_rel, idle_ckpt);
    endtask

    task automatic random_rename();
        rename_op(1'b1, random_arch_idx(), random_arch_idx(), random_arch_idx());
    endtask

    task automatic branch_rename(input rename_if_pkg::arch_idx_t dest, input int slot);
        drive_cycle(make_req(1'b1, dest, random_arch_idx(), random_arch_idx()), idle_rel,
                    make_ckpt(1'b1, slot, 1'b0, 0));
    endtask

    task automatic release_tag(input rename_if_pkg::phys_tag_t tag);
        rename_if_pkg::release_t rl;
        rl.valid = 1'b1;
        rl.tag   = tag;
        rel_q.push_back(tag);
        drive_cycle(idle_req, rl, idle_ckpt);
    endtask

    task automatic save_to(input int slot);
        drive_cycle(idle_req, idle_rel, make_ckpt(1'b1, slot, 1'b0, 0));
    endtask

    // restore, read a few registers, then check the first tag popped
    task automatic restore_and_probe(input int slot, input int first_tag);
        drive_cycle(idle_req, idle_rel, make_ckpt(1'b0, 0, 1'b1, slot));
        for (int i = 0; i < 3; i++) begin
            rename_op(1'b0, '0, random_arch_idx(), random_arch_idx());
        end
        random_rename();
        check_value(last_rsp.dest_tag, first_tag, "first dest_tag after restore");
    endtask

    task automatic reset_mapping_test();
        rename_if_pkg::arch_idx_t s1;
        rename_if_pkg::arch_idx_t s2;
        for (int i = 0; i < 4; i++) begin
            s1 = random_arch_idx();
            s2 = random_arch_idx();
            rename_op(1'b0, '0, s1, s2);
            check_value(last_rsp.src1_tag, s1, "identity src1_tag");
            check_value(last_rsp.src2_tag, s2, "identity src2_tag");
        end
        for (int i = 0; i < 6; i++) begin
            rename_op(1'b1, rename_if_pkg::arch_idx_t'(i + 1), random_arch_idx(),
                      random_arch_idx());
            check_value(last_rsp.dest_tag, 32 + i, "initial dest_tag");
            check_value(last_rsp.old_tag, i + 1, "initial old_tag");
        end
    endtask

    task automatic dependency_test();
        rename_if_pkg::arch_idx_t d;
        int t1;
        int t2;
        d = random_arch_idx();
        rename_op(1'b1, d, random_arch_idx(), random_arch_idx());
        t1 = last_rsp.dest_tag;
        rename_op(1'b0, '0, d, d);
        check_value(last_rsp.src1_tag, t1, "dependent src1_tag");
        rename_op(1'b1, d, d, random_arch_idx());
        check_value(last_rsp.src1_tag, t1, "own destination read");
        check_value(last_rsp.old_tag, t1, "old_tag of rewrite");
        t2 = last_rsp.dest_tag;
        rename_op(1'b0, '0, d, random_arch_idx());
        check_value(last_rsp.dest_tag, 0, "dest_tag without destination");
        check_value(last_rsp.src1_tag, t2, "src1_tag after rewrite");
        random_rename();
        check_value(last_rsp.dest_tag, t2 + 1, "tag after request without destination");
    endtask

    task automatic recycle_test();
        int exp_tag;
        rel_q.delete();
        for (int i = 0; i < 8; i++) begin
            release_tag(rename_if_pkg::phys_tag_t'(3 * i + 1));
        end
        while (model_free_count() > 8) begin
            random_rename();                    // drain the initial tags
        end
        while (rel_q.size() > 0) begin
            exp_tag = rel_q.pop_front();
            random_rename();
            check_value(last_rsp.dest_tag, exp_tag, "recycled dest_tag");
        end
    endtask

    task automatic empty_list_test();
        rename_if_pkg::arch_idx_t d;
        int prev;
        check_value(ready, 0, "ready with an empty free list");
        d = random_arch_idx();
        rename_op(1'b0, '0, d, d);
        prev = last_rsp.src1_tag;
        rename_op(1'b1, d, random_arch_idx(), random_arch_idx());
        check_value(last_rsp.valid, 0, "response to a refused request");
        rename_op(1'b0, '0, d, d);
        check_value(last_rsp.src1_tag, prev, "mapping after a refused request");
        release_tag(7'd77);
        check_value(ready, 1, "ready after one release");
        rename_op(1'b1, d, random_arch_idx(), random_arch_idx());
        check_value(last_rsp.dest_tag, 77, "dest_tag of the retried request");
    endtask

    task automatic restore_test();
        rename_if_pkg::arch_idx_t d;
        rename_if_pkg::arch_idx_t dests [4];
        int after_save [4];
        int branch_tag;
        for (int i = 0; i < 20; i++) begin
            release_tag(rename_if_pkg::phys_tag_t'(40 + i));
        end
        d = random_arch_idx();
        branch_rename(d, 3);
        branch_tag = last_rsp.dest_tag;
        for (int k = 0; k < 4; k++) begin
            dests[k] = random_arch_idx();
            rename_op(1'b1, dests[k], random_arch_idx(), random_arch_idx());
            after_save[k] = last_rsp.dest_tag;
        end
        rel_q.delete();
        release_tag(7'd100);
        release_tag(7'd101);
        // a request in the restore cycle is refused
        drive_cycle(make_req(1'b1, d, d, d), idle_rel, make_ckpt(1'b0, 0, 1'b1, 3));
        check_value(last_rsp.valid, 0, "response in the restore cycle");
        rename_op(1'b0, '0, d, d);
        check_value(last_rsp.src1_tag, branch_tag, "src1_tag after restore");
        for (int k = 0; k < 4; k++) begin
            rename_op(1'b1, dests[k], random_arch_idx(), random_arch_idx());
            check_value(last_rsp.dest_tag, after_save[k], "repeated dest_tag");
        end
        while (model_free_count() > 2) begin
            random_rename();
        end
        random_rename();
        check_value(last_rsp.dest_tag, 100, "tag released before restore");
        random_rename();
        check_value(last_rsp.dest_tag, 101, "tag released before restore");
    endtask

    task automatic slot_test();
        int first_tag [3];
        for (int i = 0; i < 30; i++) begin
            release_tag(rename_if_pkg::phys_tag_t'(64 + i));
        end
        save_to(0);
        random_rename();
        first_tag[0] = last_rsp.dest_tag;
        random_rename();
        branch_rename(random_arch_idx(), 5);
        random_rename();
        first_tag[1] = last_rsp.dest_tag;   // slot 5
        random_rename();
        save_to(7);
        random_rename();
        first_tag[2] = last_rsp.dest_tag;   // slot 7
        random_rename();
        random_rename();
        restore_and_probe(5, first_tag[1]);
        restore_and_probe(0, first_tag[0]);
        restore_and_probe(7, first_tag[2]);
        restore_and_probe(5, first_tag[1]);
    endtask

    initial begin
        reset = 1'b1;
        req   = '0;
        rel   = '0;
        ckpt  = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        model_reset();
        check_value(rsp.valid, 0, "rsp.valid after reset");
        check_value(ready, 1, "ready after reset");
        reset_mapping_test();
        dependency_test();
        recycle_test();
        empty_list_test();
        restore_test();
        slot_test();
        @(negedge clk);
        if (i_dut.i_rename_asrt.fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
rename_cfg_pkg.sv
rename_if_pkg.sv
free_list.sv
map_table.sv
checkpoint_store.sv
rename_unit.sv
rename_unit_assertions.sv
tb_rename_unit.sv
